// ==== src/rdo_pkg.sv ====
//----------------------------------------
// Luma 4x4 RDO shared definitions
//----------------------------------------

package rdo_pkg;

    //----------------------------------------
    // Data widths
    //----------------------------------------
    // Signed residual coefficient
    localparam int COEF_W   = 16;
    // Signed quantized level
    localparam int LEVEL_W  = 16;
    // Coefficients in one 4x4 block
    localparam int NUM_COEF = 16;
    // Block cost, sum of squared levels
    localparam int COST_W   = 32;
    // Intra mode number
    localparam int MODE_W   = 4;
    // Quantizer parameter, legal 0 to 51
    localparam int QP_W     = 6;
    // Candidate count, legal 1 to 9
    localparam int CNT_W    = 4;
    // Scale table entry
    localparam int SCALE_W  = 14;
    // Quantizer right shift amount
    localparam int SHIFT_W  = 5;

    //----------------------------------------
    // Quantizer constants
    //----------------------------------------
    // Level magnitude clamp, keeps 16 squares below 2^32
    localparam logic [LEVEL_W-1:0] LEVEL_MAX = 16'd2047;
    // qp steps per doubling of the step size
    localparam logic [QP_W-1:0] QP_PERIOD = 6'd6;
    // Base shift, total shift adds qp / 6
    localparam logic [SHIFT_W-1:0] QBITS_BASE = 5'd15;
    // Scale by qp % 6, entry 0 in the low bits
    localparam logic [5:0][SCALE_W-1:0] QUANT_SCALE = {
        14'd7282, 14'd8192, 14'd9362, 14'd10082, 14'd11916, 14'd13107
    };

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        WAIT_COEF,
        QUANT,
        COST,
        UPDATE,
        FINISH
    } rdo_state_e;

endpackage

// ==== src/rdo_ctrl.sv ====
//----------------------------------------
// RDO candidate sequencer
//----------------------------------------
`timescale 1ns/1ps

module rdo_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                coef_valid,
    input  logic                cost_done,
    input  logic                last_cand,
    output rdo_pkg::rdo_state_e state,
    output logic                cap_en,
    output logic                sel_clear,
    output logic                sel_update,
    output logic                busy,
    output logic                done
);

    rdo_pkg::rdo_state_e state_next;
    // Last candidate flag sampled when its cost completes
    logic                last_q;

    //----------------------------------------
    // State register
    //----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= rdo_pkg::IDLE;
            last_q <= 1'b0;
        end else begin
            state <= state_next;
            // Counter flag is valid before its increment on cost_done
            if (state == rdo_pkg::COST && cost_done) begin
                last_q <= last_cand;
            end else if (sel_clear) begin
                last_q <= 1'b0;
            end
        end
    end

    //----------------------------------------
    // Next state
    //----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            rdo_pkg::IDLE: begin
                if (start) begin
                    state_next = rdo_pkg::WAIT_COEF;
                end
            end
            rdo_pkg::WAIT_COEF: begin
                if (coef_valid) begin
                    state_next = rdo_pkg::QUANT;
                end
            end
            // Levels register during this cycle
            rdo_pkg::QUANT: state_next = rdo_pkg::COST;
            // Hold until the squared sum is ready
            rdo_pkg::COST: begin
                if (cost_done) begin
                    state_next = rdo_pkg::UPDATE;
                end
            end
            rdo_pkg::UPDATE: begin
                state_next = last_q ? rdo_pkg::FINISH : rdo_pkg::WAIT_COEF;
            end
            rdo_pkg::FINISH: state_next = rdo_pkg::IDLE;
            default: state_next = rdo_pkg::IDLE;
        endcase
    end

    // Start only honoured while idle
    assign sel_clear  = (state == rdo_pkg::IDLE) && start;
    // Coefficients only taken while waiting
    assign cap_en     = (state == rdo_pkg::WAIT_COEF) && coef_valid;
    assign sel_update = (state == rdo_pkg::UPDATE);
    assign busy       = (state != rdo_pkg::IDLE);
    // One cycle, busy drops right after
    assign done       = (state == rdo_pkg::FINISH);

endmodule

// ==== src/cand_counter.sv ====
//----------------------------------------
// Candidate completion counter
//----------------------------------------
`timescale 1ns/1ps

module cand_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  logic                    count_en,
    input  logic [rdo_pkg::CNT_W-1:0] cand_count,
    output logic                    last_cand
);

    // Requested number of candidates
    logic [rdo_pkg::CNT_W-1:0] target_q;
    // Candidates already costed
    logic [rdo_pkg::CNT_W-1:0] done_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            target_q <= '0;
            done_cnt <= '0;
        end else if (clear) begin
            // New block latches its count
            target_q <= cand_count;
            done_cnt <= '0;
        end else if (count_en) begin
            done_cnt <= done_cnt + 1'b1;
        end
    end

    // Next completion is the final one
    assign last_cand = ((done_cnt + 1'b1) == target_q);

endmodule

// ==== src/quant4x4.sv ====
//----------------------------------------
// 4x4 coefficient quantizer
//----------------------------------------
`timescale 1ns/1ps

module quant4x4 (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           load,
    input  logic [rdo_pkg::QP_W-1:0]                       qp,
    input  logic [rdo_pkg::NUM_COEF*rdo_pkg::COEF_W-1:0]   coefs,
    output logic [rdo_pkg::NUM_COEF*rdo_pkg::LEVEL_W-1:0]  levels,
    output logic                                           lvl_valid
);

    logic [rdo_pkg::QP_W-1:0]                      qp_div;
    logic [rdo_pkg::QP_W-1:0]                      qp_mod;
    logic [rdo_pkg::SCALE_W-1:0]                   scale;
    logic [rdo_pkg::SHIFT_W-1:0]                   shift_amt;
    logic [rdo_pkg::NUM_COEF*rdo_pkg::LEVEL_W-1:0] levels_next;

    // One coefficient to one clamped signed level
    function automatic logic [rdo_pkg::LEVEL_W-1:0] quant_one(
        input logic [rdo_pkg::COEF_W-1:0]  coef,
        input logic [rdo_pkg::SCALE_W-1:0] scl,
        input logic [rdo_pkg::SHIFT_W-1:0] shf
    );
        logic [rdo_pkg::COEF_W:0]                  mag;
        logic [rdo_pkg::COEF_W+rdo_pkg::SCALE_W:0] prod;
        logic [rdo_pkg::COEF_W+rdo_pkg::SCALE_W:0] q;
        logic [rdo_pkg::LEVEL_W-1:0]               lvl_mag;
        // Extra bit so that -32768 has a magnitude
        mag = coef[rdo_pkg::COEF_W-1] ? -{coef[rdo_pkg::COEF_W-1], coef} : {1'b0, coef};
        prod = mag * scl;
        q = prod >> shf;
        // Saturate the magnitude
        if (q > rdo_pkg::LEVEL_MAX) begin
            lvl_mag = rdo_pkg::LEVEL_MAX;
        end else begin
            lvl_mag = q[rdo_pkg::LEVEL_W-1:0];
        end
        // Sign of the coefficient restored
        return coef[rdo_pkg::COEF_W-1] ? -lvl_mag : lvl_mag;
    endfunction

    //----------------------------------------
    // Step size from qp
    //----------------------------------------
    always_comb begin
        qp_div    = qp / rdo_pkg::QP_PERIOD;
        qp_mod    = qp % rdo_pkg::QP_PERIOD;
        scale     = rdo_pkg::QUANT_SCALE[qp_mod];
        // qp / 6 never exceeds 10
        shift_amt = rdo_pkg::QBITS_BASE + qp_div[rdo_pkg::SHIFT_W-1:0];
        for (int i = 0; i < rdo_pkg::NUM_COEF; i++) begin
            levels_next[i*rdo_pkg::LEVEL_W +: rdo_pkg::LEVEL_W] =
                quant_one(coefs[i*rdo_pkg::COEF_W +: rdo_pkg::COEF_W], scale, shift_amt);
        end
    end

    // Level payload
    always_ff @(posedge clk) begin
        if (load) begin
            levels <= levels_next;
        end
    end

    // Valid one cycle after load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lvl_valid <= 1'b0;
        end else begin
            lvl_valid <= load;
        end
    end

endmodule

// ==== src/level_cost.sv ====
//----------------------------------------
// Sum of squared levels
//----------------------------------------
`timescale 1ns/1ps

module level_cost (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           start,
    input  logic [rdo_pkg::NUM_COEF*rdo_pkg::LEVEL_W-1:0]  levels,
    output logic [rdo_pkg::COST_W-1:0]                     sum,
    output logic                                           done
);

    // Delay line, sum lands one cycle after start
    logic                       shift_q;
    logic [rdo_pkg::COST_W-1:0] sq_sum;

    // Squares of all sixteen levels
    function automatic logic [rdo_pkg::COST_W-1:0] sum_sq(
        input logic [rdo_pkg::NUM_COEF*rdo_pkg::LEVEL_W-1:0] lv
    );
        logic signed [rdo_pkg::LEVEL_W-1:0] lvl;
        logic signed [rdo_pkg::COST_W-1:0]  sq;
        logic [rdo_pkg::COST_W-1:0]         acc;
        acc = '0;
        for (int i = 0; i < rdo_pkg::NUM_COEF; i++) begin
            lvl = signed'(lv[i*rdo_pkg::LEVEL_W +: rdo_pkg::LEVEL_W]);
            // Operands widen to 32 bits before the multiply
            sq  = lvl * lvl;
            acc = acc + unsigned'(sq);
        end
        return acc;
    endfunction

    assign sq_sum = sum_sq(levels);

    //----------------------------------------
    // Control and result registers
    //----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q <= 1'b0;
            done    <= 1'b0;
        end else begin
            shift_q <= start;
            done    <= shift_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else if (start) begin
            // Fresh block
            sum <= '0;
        end else if (shift_q) begin
            sum <= sq_sum;
        end
    end

endmodule

// ==== src/best_mode_sel.sv ====
//----------------------------------------
// Minimum cost mode selector
//----------------------------------------
`timescale 1ns/1ps

module best_mode_sel (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       clear,
    input  logic                       update,
    input  logic [rdo_pkg::MODE_W-1:0] cand_mode,
    input  logic [rdo_pkg::COST_W-1:0] cost,
    output logic [rdo_pkg::MODE_W-1:0] best_mode,
    output logic [rdo_pkg::COST_W-1:0] best_cost
);

    // Strictly lower, so the earliest of equal costs stays
    logic better;

    assign better = (cost < best_cost);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_mode <= '0;
            best_cost <= '1;
        end else if (clear) begin
            // All ones, any real cost beats it
            best_mode <= '0;
            best_cost <= '1;
        end else if (update && better) begin
            best_mode <= cand_mode;
            best_cost <= cost;
        end
    end

endmodule

// ==== src/rdo_luma4_top.sv ====
//----------------------------------------
// Luma 4x4 RDO cost stage
//----------------------------------------
`timescale 1ns/1ps

module rdo_luma4_top (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         start,
    input  logic [rdo_pkg::QP_W-1:0]                     qp,
    input  logic [rdo_pkg::CNT_W-1:0]                    cand_count,
    input  logic                                         coef_valid,
    input  logic [rdo_pkg::MODE_W-1:0]                   cand_mode,
    input  logic [rdo_pkg::NUM_COEF*rdo_pkg::COEF_W-1:0] coefs,
    output logic                                         busy,
    output logic                                         done,
    output logic [rdo_pkg::MODE_W-1:0]                   best_mode,
    output logic [rdo_pkg::COST_W-1:0]                   best_cost
);

    rdo_pkg::rdo_state_e                           ctrl_state;
    logic                                          cap_en;
    logic                                          sel_clear;
    logic                                          sel_update;
    logic                                          last_cand;
    logic                                          lvl_valid;
    logic                                          cost_done;
    logic [rdo_pkg::QP_W-1:0]                      qp_q;
    logic [rdo_pkg::MODE_W-1:0]                    mode_q;
    logic [rdo_pkg::NUM_COEF*rdo_pkg::LEVEL_W-1:0] levels;
    logic [rdo_pkg::COST_W-1:0]                    cost_sum;

    //----------------------------------------
    // Block and candidate capture
    //----------------------------------------
    always_ff @(posedge clk) begin
        // qp held for the whole block
        if (ctrl_state == rdo_pkg::IDLE && start) begin
            qp_q <= qp;
        end
        // Mode rides along with its coefficients
        if (cap_en) begin
            mode_q <= cand_mode;
        end
    end

    rdo_ctrl rdo_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .coef_valid (coef_valid),
        .cost_done  (cost_done),
        .last_cand  (last_cand),
        .state      (ctrl_state),
        .cap_en     (cap_en),
        .sel_clear  (sel_clear),
        .sel_update (sel_update),
        .busy       (busy),
        .done       (done)
    );

    // Counts on each finished cost
    cand_counter cand_counter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (sel_clear),
        .count_en   (cost_done),
        .cand_count (cand_count),
        .last_cand  (last_cand)
    );

    quant4x4 quant4x4_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (cap_en),
        .qp        (qp_q),
        .coefs     (coefs),
        .levels    (levels),
        .lvl_valid (lvl_valid)
    );

    level_cost level_cost_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (lvl_valid),
        .levels (levels),
        .sum    (cost_sum),
        .done   (cost_done)
    );

    best_mode_sel best_mode_sel_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (sel_clear),
        .update    (sel_update),
        .cand_mode (mode_q),
        .cost      (cost_sum),
        .best_mode (best_mode),
        .best_cost (best_cost)
    );

endmodule

// ==== bench/rdo_luma4_assert.sv ====
//----------------------------------------
// RDO protocol assertions
//----------------------------------------
`timescale 1ns/1ps

module rdo_luma4_assert (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done
);

    // done is a single cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done held for more than one cycle");

    // Only at the end of a busy block
    done_while_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(busy))
        else $error("done pulsed without a busy block before it");

    // busy falls right after done
    busy_after_done: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
        else $error("busy still high after done");

    // No other way out of busy
    busy_fall_on_done: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(done))
        else $error("busy fell without done");

endmodule

bind rdo_luma4_top rdo_luma4_assert rdo_luma4_assert_i (
    .clk   (clk),
    .rst_n (rst_n),
    .busy  (busy),
    .done  (done)
);

// ==== bench/rdo_luma4_checker.sv ====
//----------------------------------------
// RDO result checker
//----------------------------------------
`timescale 1ns/1ps

module rdo_luma4_checker (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       done,
    input logic [rdo_pkg::MODE_W-1:0] best_mode,
    input logic [rdo_pkg::COST_W-1:0] best_cost
);

    // Pending test
    string       exp_name;
    int          exp_mode;
    int unsigned exp_cost;
    bit          armed = 1'b0;
    // Running totals read by the testbench
    int          pass_count = 0;
    int          fail_count = 0;

    // Expected result of the next block
    task automatic arm(input string name, input int mode, input int unsigned cost);
        exp_name = name;
        exp_mode = mode;
        exp_cost = cost;
        armed    = 1'b1;
    endtask

    // Block stalled before its busy or done
    task automatic note_missing(input string name, input string what);
        $display("FAIL %s: %s", name, what);
        fail_count++;
        armed = 1'b0;
    endtask

    //----------------------------------------
    // Compare on each done
    //----------------------------------------
    always @(posedge clk) begin
        if (rst_n && done) begin
            if (!armed) begin
                $display("Unexpected done pulse with no block in progress");
                fail_count++;
            end else if (best_mode != exp_mode[rdo_pkg::MODE_W-1:0] ||
                         best_cost != exp_cost) begin
                $display("FAIL %s: expected mode %0d cost %0d, actual mode %0d cost %0d",
                         exp_name, exp_mode, exp_cost, best_mode, best_cost);
                fail_count++;
            end else begin
                $display("PASS %s: mode %0d cost %0d", exp_name, best_mode, best_cost);
                pass_count++;
            end
            armed = 1'b0;
        end
    end

endmodule

// ==== bench/rdo_luma4_tb.sv ====
//----------------------------------------
// Luma 4x4 RDO testbench
//----------------------------------------
`timescale 1ns/1ps

module rdo_luma4_tb;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [5:0]  qp;
    logic [3:0]  cand_count;
    logic        coef_valid;
    logic [3:0]  cand_mode;
    logic [255:0] coefs;
    logic        busy;
    logic        done;
    logic [3:0]  best_mode;
    logic [31:0] best_cost;

    // Block records
    string       blk_name[$];
    int          blk_qp[$];
    int          blk_cnt[$];
    int          blk_mode[$];
    int unsigned blk_cost[$];
    int          blk_noise[$];
    int          blk_first[$];
    // Candidate records
    int          cand_mode_q[$];
    logic [255:0] cand_coef_q[$];
    bit          load_ok = 1'b0;

    rdo_luma4_top rdo_luma4_top_i (
        .clk(clk), .rst_n(rst_n), .start(start), .qp(qp), .cand_count(cand_count),
        .coef_valid(coef_valid), .cand_mode(cand_mode), .coefs(coefs),
        .busy(busy), .done(done), .best_mode(best_mode), .best_cost(best_cost)
    );

    rdo_luma4_checker rdo_luma4_checker_i (
        .clk(clk), .rst_n(rst_n), .done(done), .best_mode(best_mode), .best_cost(best_cost)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //----------------------------------------
    // Stimulus file
    //----------------------------------------
    task automatic load_stimulus(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       tag;
        string       name;
        int          qp_v;
        int          cnt_v;
        int          mode_v;
        int          noise_v;
        int unsigned cost_v;
        logic [15:0] c [16];
        logic [255:0] packed_v;
        ok = 1'b0;
        fd = $fopen("bench/rdo_stimulus.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
            if (line.getc(0) == "B") begin
                n = $sscanf(line, "%s %s %d %d %d %d %d", tag, name, qp_v, cnt_v,
                            mode_v, cost_v, noise_v);
                if (n != 7) return;
                blk_name.push_back(name);
                blk_qp.push_back(qp_v);
                blk_cnt.push_back(cnt_v);
                blk_mode.push_back(mode_v);
                blk_cost.push_back(cost_v);
                blk_noise.push_back(noise_v);
                blk_first.push_back(cand_mode_q.size());
            end else begin
                n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            tag, mode_v, c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7],
                            c[8], c[9], c[10], c[11], c[12], c[13], c[14], c[15]);
                if (n != 18) return;
                // Coefficient 0 in the low bits
                for (int i = 0; i < 16; i++) packed_v[i*16 +: 16] = c[i];
                cand_mode_q.push_back(mode_v);
                cand_coef_q.push_back(packed_v);
            end
        end
        $fclose(fd);
        ok = (blk_name.size() > 0);
    endtask

    // One block, next candidate only after the selector update of the last one
    task automatic run_block(input int b);
        int idx;
        int n;
        rdo_luma4_checker_i.arm(blk_name[b], blk_mode[b], blk_cost[b]);
        @(negedge clk);
        start      = 1'b1;
        qp         = blk_qp[b][5:0];
        cand_count = blk_cnt[b][3:0];
        @(negedge clk);
        start = 1'b0;
        n = 0;
        while (!busy && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!busy) begin
            rdo_luma4_checker_i.note_missing(blk_name[b], "busy never rose after start");
            return;
        end
        for (int k = 0; k < blk_cnt[b]; k++) begin
            idx = blk_first[b] + k;
            coef_valid = 1'b1;
            cand_mode  = cand_mode_q[idx][3:0];
            coefs      = cand_coef_q[idx];
            @(negedge clk);
            coef_valid = 1'b0;
            if (blk_noise[b] != 0) begin
                // Stray strobes through quantize, cost and update
                coef_valid = 1'b1;
                cand_mode  = 4'hf;
                coefs      = {16{16'h7fff}};
                start      = 1'b1;
                qp         = 6'd0;
                cand_count = 4'hf;
            end
            // Levels, cost and selector update take four more cycles
            repeat (4) @(negedge clk);
            coef_valid = 1'b0;
            start      = 1'b0;
        end
        n = 0;
        while (!done && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            rdo_luma4_checker_i.note_missing(blk_name[b],
                                             "no done pulse after the last candidate");
        end else begin
            while (busy) @(negedge clk);
        end
    endtask

    //----------------------------------------
    // Main sequence
    //----------------------------------------
    initial begin
        bit ok;
        rst_n      = 1'b0;
        start      = 1'b0;
        qp         = '0;
        cand_count = '0;
        coef_valid = 1'b0;
        cand_mode  = '0;
        coefs      = '0;
        load_stimulus(ok);
        if (!ok) begin
            $display("Could not read a valid bench/rdo_stimulus.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            load_ok = 1'b1;
            repeat (10) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            for (int b = 0; b < blk_name.size(); b++) run_block(b);
            repeat (4) @(negedge clk);
            $display("Tests: %0d, passed %0d, failed %0d", blk_name.size(),
                     rdo_luma4_checker_i.pass_count, rdo_luma4_checker_i.fail_count);
            if (rdo_luma4_checker_i.fail_count == 0 &&
                rdo_luma4_checker_i.pass_count == blk_name.size()) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    // Watchdog sized for nine candidates in every block
    initial begin
        wait (load_ok && rst_n);
        repeat (blk_name.size() * (9 * 8 + 20)) @(posedge clk);
        $display("Watchdog timeout, the run did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== rdo_luma4.f ====
src/rdo_pkg.sv
src/rdo_ctrl.sv
src/cand_counter.sv
src/quant4x4.sv
src/level_cost.sv
src/best_mode_sel.sv
src/rdo_luma4_top.sv
bench/rdo_luma4_assert.sv
bench/rdo_luma4_checker.sv
bench/rdo_luma4_tb.sv

// ==== Makefile ====
# Verilator build and run of the luma 4x4 RDO cost stage

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f rdo_luma4.f \
		--top-module rdo_luma4_tb -o Vrdo_luma4_tb
	./obj_dir/Vrdo_luma4_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/rdo_stimulus.txt ====
# B name qp count expected_mode expected_cost noise (decimal)
# C mode c0 .. c15 (mode decimal, coefficients 16-bit hex)
B zero_single 20 1 2 0 0
C 2 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
B qp4_mix 4 1 1 36 0
C 1 0010 FFF0 0008 0003 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
B qp28_neg 28 1 0 289 0
C 0 0100 FF00 0400 FFC0 003F 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
B qp0_round 0 1 5 11 0
C 5 000A FFFB 0003 0002 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
B qp10_pair 10 1 7 200 0
C 7 0050 FFB0 0007 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
B clamp_tie 0 2 3 67043344 0
C 3 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
C 4 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
B lowest_last 4 3 8 1 0
C 0 0010 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 1 0008 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 8 0004 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
B tie_first 4 3 6 4 0
C 6 0008 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 2 0010 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 5 FFF8 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
B stray_strobes 28 2 3 1 1
C 1 0080 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 3 0040 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
B nine_cands 4 9 3 9 0
C 0 0020 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 1 0018 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 2 0014 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 3 000C 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 4 0010 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 5 FFF4 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 6 0014 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 7 0024 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C 8 0030 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
